//--- logic/hack_pkg.sv
package hack_pkg;

  typedef logic [15:0] word_t;

  // the six ALU control bits in instruction order, zx at the top
  typedef struct packed {
    logic zx;
    logic nx;
    logic zy;
    logic ny;
    logic f;
    logic no;
  } alu_ctrl_t;

  // an address load carries a 15-bit constant under a clear flag bit
  typedef struct packed {
    logic        flag;
    logic [14:0] value;
  } a_form_t;

  // a compute instruction, with dest ordered A, D, M and jump ordered lt, eq, gt
  typedef struct packed {
    logic       flag;
    logic [1:0] unused;
    logic       a;
    alu_ctrl_t  ctrl;
    logic [2:0] dest;
    logic [2:0] jump;
  } c_form_t;

  // the same instruction word read either way, the flag bit picks the view
  typedef union packed {
    a_form_t a_form;
    c_form_t c_form;
  } hack_inst_u;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [15:0] address;
    word_t       wdata;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] address;
    word_t       data;
  } write_event_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] index;
    word_t      data;
  } pixel_t;

  localparam logic [15:0] VRAM_BASE  = 16'h4000;
  localparam logic [15:0] VRAM_LIMIT = 16'h5fff;
  localparam int DATA_WORDS = 1024;
  localparam int VRAM_WORDS = 256;
  localparam int PROG_WORDS = 256;
  localparam int DATA_ADDR_BITS = $clog2(DATA_WORDS);
  localparam int VRAM_ADDR_BITS = $clog2(VRAM_WORDS);
  localparam int PROG_ADDR_BITS = $clog2(PROG_WORDS);

  // scanout cadence and the CPU's extra wait once video memory is free
  localparam int SCAN_PERIOD = 4;
  localparam int SCAN_COUNT_BITS = $clog2(SCAN_PERIOD);
  localparam int VRAM_SETTLE = 2;
  localparam int SETTLE_BITS = $clog2(VRAM_SETTLE + 1);

  // true when an address falls inside the shared video window
  function automatic logic in_vram(input logic [15:0] address);
    return (address >= VRAM_BASE) && (address <= VRAM_LIMIT);
  endfunction

endpackage

//--- logic/hack_alu.sv
module hack_alu import hack_pkg::*; (
  input  word_t     x,
  input  word_t     y,
  input  alu_ctrl_t ctrl,
  output word_t     result,
  output logic      zero,
  output logic      negative
);

  word_t x_zeroed;
  word_t x_final;
  word_t y_zeroed;
  word_t y_final;
  word_t combined;

  always_comb begin
    // each operand may be forced to zero first and then inverted
    x_zeroed = ctrl.zx ? '0 : x;
    x_final  = ctrl.nx ? ~x_zeroed : x_zeroed;
    y_zeroed = ctrl.zy ? '0 : y;
    y_final  = ctrl.ny ? ~y_zeroed : y_zeroed;

    // f picks between a plain add and a bitwise AND of the two operands
    combined = ctrl.f ? (x_final + y_final) : (x_final & y_final);

    // the last control bit inverts whatever came out of the function stage
    result = ctrl.no ? ~combined : combined;
  end

  // flags feed the jump condition in the CPU
  assign zero     = (result == '0);
  assign negative = result[15];

endmodule

//--- logic/hack_cpu.sv
module hack_cpu import hack_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  hack_inst_u  instruction,
  input  word_t       rdata,
  input  logic        mem_busy,
  output mem_req_t    mem_req,
  output logic [15:0] prog_counter
);

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    MEM_READ,
    MEM_FETCH,
    WRITE_BACK
  } cpu_state_t;

  cpu_state_t state;

  word_t a_reg;
  word_t d_reg;
  // second ALU operand which holds either A or the word read from memory
  word_t y_reg;

  // fields of the compute instruction kept until write-back
  alu_ctrl_t  ctrl_q;
  logic [2:0] dest_q;
  logic [2:0] jump_q;

  logic [SETTLE_BITS-1:0] mem_wait;

  word_t alu_result;
  logic  alu_zero;
  logic  alu_negative;
  logic  alu_positive;
  logic  take_jump;
  logic  fast_mem;
  logic  write_ready;

  hack_alu alu0 (
    .x        (d_reg),
    .y        (y_reg),
    .ctrl     (ctrl_q),
    .result   (alu_result),
    .zero     (alu_zero),
    .negative (alu_negative)
  );

  // anything outside the video window answers in one cycle and ignores busy
  assign fast_mem = !in_vram(a_reg);

  assign alu_positive = !(alu_negative || alu_zero);
  assign take_jump = (jump_q[2] && alu_negative) ||
                     (jump_q[1] && alu_zero) ||
                     (jump_q[0] && alu_positive);

  // write-back may finish unless it stores to video memory that is still busy
  assign write_ready = !dest_q[0] || fast_mem || !mem_busy;

  always_comb begin
    // the data address is always A, and a store always carries the ALU result
    mem_req.valid   = (state == MEM_READ) || ((state == WRITE_BACK) && dest_q[0]);
    mem_req.write   = (state == WRITE_BACK);
    mem_req.address = a_reg;
    mem_req.wdata   = alu_result;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= FETCH;
      prog_counter <= '0;
      a_reg        <= '0;
      d_reg        <= '0;
      mem_wait     <= '0;
    end else begin
      case (state)
        FETCH: begin
          // program memory needs this cycle to present the word at the new counter
          state <= DECODE;
        end

        DECODE: begin
          if (instruction.c_form.flag) begin
            ctrl_q <= instruction.c_form.ctrl;
            dest_q <= instruction.c_form.dest;
            jump_q <= instruction.c_form.jump;
            if (instruction.c_form.a) begin
              state <= MEM_READ;
            end else begin
              y_reg <= a_reg;
              state <= WRITE_BACK;
            end
          end else begin
            a_reg <= {1'b0, instruction.a_form.value};
            state <= FETCH;
          end
          // step ahead on the guess that no jump follows and let a taken jump overwrite it
          prog_counter <= prog_counter + 16'd1;
        end

        MEM_READ: begin
          if (fast_mem) begin
            state <= MEM_FETCH;
          end else if (mem_wait == '0) begin
            // the arbiter takes the read in the first cycle with busy low
            if (!mem_busy) begin
              mem_wait <= mem_wait + 1'b1;
            end
          end else if (mem_wait == SETTLE_BITS'(VRAM_SETTLE)) begin
            mem_wait <= '0;
            state    <= MEM_FETCH;
          end else begin
            mem_wait <= mem_wait + 1'b1;
          end
        end

        MEM_FETCH: begin
          y_reg <= rdata;
          state <= WRITE_BACK;
        end

        WRITE_BACK: begin
          if (write_ready) begin
            if (dest_q[2]) begin
              a_reg <= alu_result;
            end
            if (dest_q[1]) begin
              d_reg <= alu_result;
            end
            if (take_jump) begin
              prog_counter <= a_reg;
            end
            // without a jump the next word was already read during this instruction
            state <= take_jump ? FETCH : DECODE;
          end
        end

        default: begin
          state <= FETCH;
        end
      endcase
    end
  end

  // a video store seen with busy high is presented again unchanged in the next cycle
  assert property (@(posedge clk) disable iff (reset)
    (mem_req.valid && mem_req.write && in_vram(mem_req.address) && mem_busy)
      |=> $stable(mem_req));

endmodule

//--- logic/program_memory.sv
module program_memory import hack_pkg::*; (
  input  logic        clk,
  input  logic        load_valid,
  input  logic [15:0] load_address,
  input  word_t       load_data,
  input  logic [15:0] address,
  output hack_inst_u  instruction
);

  word_t words [PROG_WORDS];

  always_ff @(posedge clk) begin
    // programs arrive through the load port, normally while the CPU is held in reset
    if (load_valid) begin
      words[load_address[PROG_ADDR_BITS-1:0]] <= load_data;
    end
    // the word for the current counter shows up one cycle later
    instruction <= words[address[PROG_ADDR_BITS-1:0]];
  end

endmodule

//--- logic/memory_map.sv
module memory_map import hack_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  mem_req_t     cpu_req,
  output word_t        rdata,
  output logic         mem_busy,
  output mem_req_t     vram_req,
  input  word_t        vram_rdata,
  input  logic         vram_busy,
  output write_event_t write_event
);

  word_t data_words [DATA_WORDS];
  word_t data_rdata;

  logic vram_sel;
  // region of the last read, so the returned word comes from the right array
  logic read_vram;

  assign vram_sel = in_vram(cpu_req.address);

  always_comb begin
    vram_req       = cpu_req;
    vram_req.valid = cpu_req.valid && vram_sel;
  end

  // busy only concerns requests that land in the video window
  assign mem_busy = vram_sel && vram_busy;

  always_ff @(posedge clk) begin
    if (cpu_req.valid && !vram_sel) begin
      if (cpu_req.write) begin
        data_words[cpu_req.address[DATA_ADDR_BITS-1:0]] <= cpu_req.wdata;
      end else begin
        data_rdata <= data_words[cpu_req.address[DATA_ADDR_BITS-1:0]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      read_vram <= 1'b0;
    end else if (cpu_req.valid && !cpu_req.write) begin
      read_vram <= vram_sel;
    end
  end

  assign rdata = read_vram ? vram_rdata : data_rdata;

  // data stores finish at once, video stores wait for the scanout to let go
  always_comb begin
    write_event.valid   = cpu_req.valid && cpu_req.write && !(vram_sel && vram_busy);
    write_event.address = cpu_req.address;
    write_event.data    = cpu_req.wdata;
  end

endmodule

//--- logic/vram_arbiter.sv
module vram_arbiter import hack_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  mem_req_t   cpu_req,
  output word_t      cpu_rdata,
  output logic       busy,
  input  logic       scan_read,
  input  logic [7:0] scan_index,
  output word_t      scan_data
);

  word_t video_words [VRAM_WORDS];

  // high in the cycle after a scan read while its word is on scan_data
  logic scan_inflight;
  logic cpu_access;
  logic [VRAM_ADDR_BITS-1:0] cpu_index;

  // video memory starts out blank so untouched pixels read as zero
  initial begin
    for (int i = 0; i < VRAM_WORDS; i++) begin
      video_words[i] = '0;
    end
  end

  // the window is larger than the array, so higher address bits alias
  assign cpu_index = cpu_req.address[VRAM_ADDR_BITS-1:0];

  // scanout always wins and owns the array for its read and return cycle
  assign busy = scan_read || scan_inflight;
  assign cpu_access = cpu_req.valid && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      scan_inflight <= 1'b0;
    end else begin
      scan_inflight <= scan_read;
    end
  end

  always_ff @(posedge clk) begin
    if (scan_read) begin
      scan_data <= video_words[scan_index];
    end
    // the CPU word is kept until the next granted CPU read replaces it
    if (cpu_access) begin
      if (cpu_req.write) begin
        video_words[cpu_index] <= cpu_req.wdata;
      end else begin
        cpu_rdata <= video_words[cpu_index];
      end
    end
  end

  // scanout must leave a gap so every read gets its own return cycle
  assert property (@(posedge clk) disable iff (reset) scan_read |-> !scan_inflight);

endmodule

//--- logic/video_scanout.sv
module video_scanout import hack_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output logic       scan_read,
  output logic [7:0] scan_index,
  input  word_t      scan_data,
  output pixel_t     pixel
);

  logic [SCAN_COUNT_BITS-1:0] period_count;
  logic                       pixel_valid;
  logic [7:0]                 pixel_index;

  // one read goes out on the last count of each period
  assign scan_read = (period_count == SCAN_COUNT_BITS'(SCAN_PERIOD - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      period_count <= '0;
      scan_index   <= '0;
      pixel_valid  <= 1'b0;
    end else begin
      period_count <= scan_read ? '0 : period_count + 1'b1;
      // the index wraps around the whole array on its own
      if (scan_read) begin
        scan_index <= scan_index + 8'd1;
      end
      pixel_valid <= scan_read;
    end
  end

  always_ff @(posedge clk) begin
    if (scan_read) begin
      pixel_index <= scan_index;
    end
  end

  // the arbiter registers the word, so it lines up with the index captured here
  always_comb begin
    pixel.valid = pixel_valid;
    pixel.index = pixel_index;
    pixel.data  = scan_data;
  end

endmodule

//--- logic/hack_system.sv
module hack_system import hack_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         load_valid,
  input  logic [15:0]  load_address,
  input  word_t        load_data,
  output write_event_t write_event,
  output pixel_t       pixel
);

  hack_inst_u  instruction;
  logic [15:0] prog_counter;
  mem_req_t    cpu_req;
  word_t       cpu_rdata;
  logic        mem_busy;
  mem_req_t    vram_req;
  word_t       vram_rdata;
  logic        vram_busy;
  logic        scan_read;
  logic [7:0]  scan_index;
  word_t       scan_data;

  hack_cpu cpu0 (
    .clk          (clk),
    .reset        (reset),
    .instruction  (instruction),
    .rdata        (cpu_rdata),
    .mem_busy     (mem_busy),
    .mem_req      (cpu_req),
    .prog_counter (prog_counter)
  );

  program_memory prog0 (
    .clk          (clk),
    .load_valid   (load_valid),
    .load_address (load_address),
    .load_data    (load_data),
    .address      (prog_counter),
    .instruction  (instruction)
  );

  memory_map map0 (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (cpu_req),
    .rdata       (cpu_rdata),
    .mem_busy    (mem_busy),
    .vram_req    (vram_req),
    .vram_rdata  (vram_rdata),
    .vram_busy   (vram_busy),
    .write_event (write_event)
  );

  vram_arbiter arb0 (
    .clk        (clk),
    .reset      (reset),
    .cpu_req    (vram_req),
    .cpu_rdata  (vram_rdata),
    .busy       (vram_busy),
    .scan_read  (scan_read),
    .scan_index (scan_index),
    .scan_data  (scan_data)
  );

  video_scanout scan0 (
    .clk        (clk),
    .reset      (reset),
    .scan_read  (scan_read),
    .scan_index (scan_index),
    .scan_data  (scan_data),
    .pixel      (pixel)
  );

endmodule

//--- test/hack_system_tb.sv
module hack_system_tb import hack_pkg::*; ();

  localparam int RESET_CYCLES  = 16;
  localparam int PATTERN_WORDS = 256;
  // cycles to let pass after the last write before the sweep is checked
  localparam int SETTLE_CYCLES = 8;

  logic         clk = 1'b0;
  logic         reset;
  logic         load_valid;
  logic [15:0]  load_address;
  word_t        load_data;
  write_event_t write_event;
  pixel_t       pixel;

  // flat image of the pattern file, split into the pieces below
  word_t        pattern_words [PATTERN_WORDS];
  write_event_t expected_writes [$];
  // what each video word should hold once the program has finished
  word_t        video_expect [VRAM_WORDS];

  int prog_len;
  int write_count;
  int scan_count;
  int writes_seen;
  int write_errors;
  int pixel_errors;
  int other_errors;
  int cycle_count;
  int cycle_limit;

  hack_system dut0 (
    .clk          (clk),
    .reset        (reset),
    .load_valid   (load_valid),
    .load_address (load_address),
    .load_data    (load_data),
    .write_event  (write_event),
    .pixel        (pixel)
  );

  always #5 clk = ~clk;

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
  end

  // file layout is program length and words, then write pairs, then scanout pairs
  task automatic read_patterns();
    int base;
    write_event_t entry;
    $readmemh("test/hack_patterns.txt", pattern_words);
    prog_len = int'(pattern_words[0]);
    assert ((prog_len > 0) && (prog_len < PATTERN_WORDS - 3)) else begin
      other_errors++;
      $display("pattern file is missing or its program length is out of range");
    end
    base = prog_len + 1;
    write_count = int'(pattern_words[base]);
    for (int i = 0; i < write_count; i++) begin
      entry.valid   = 1'b1;
      entry.address = pattern_words[base + 1 + 2 * i];
      entry.data    = pattern_words[base + 2 + 2 * i];
      expected_writes.push_back(entry);
    end
    base = base + 1 + 2 * write_count;
    scan_count = int'(pattern_words[base]);
    // untouched video words stay at their power-up zero
    for (int i = 0; i < VRAM_WORDS; i++) begin
      video_expect[i] = '0;
    end
    for (int i = 0; i < scan_count; i++) begin
      video_expect[pattern_words[base + 1 + 2 * i][7:0]] = pattern_words[base + 2 + 2 * i];
    end
  endtask

  // the load keeps going after reset drops, which is safe because the CPU
  // spends at least two cycles on each word and so never catches the loader
  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      load_valid   = 1'b1;
      load_address = 16'(i);
      load_data    = pattern_words[i + 1];
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic check_write();
    write_event_t expected;
    assert (expected_writes.size() > 0) else begin
      other_errors++;
      $display("write to address %h at time %0t came after the expected sequence ended",
               write_event.address, $time);
    end
    if (expected_writes.size() > 0) begin
      expected = expected_writes.pop_front();
      assert (write_event.address == expected.address) else begin
        write_errors++;
        $display("[ERROR] %0t write_event.address expected %h got %h",
                 $time, expected.address, write_event.address);
      end
      assert (write_event.data == expected.data) else begin
        write_errors++;
        $display("[ERROR] %0t write_event.data expected %h got %h",
                 $time, expected.data, write_event.data);
      end
      writes_seen++;
    end
  endtask

  // one full pass over video memory, each index one above the last
  task automatic check_sweep();
    logic [7:0] last_index;
    last_index = '0;
    for (int n = 0; n < VRAM_WORDS; n++) begin
      @(negedge clk);
      while (!pixel.valid) begin
        @(negedge clk);
      end
      if (n > 0) begin
        assert (pixel.index == last_index + 8'd1) else begin
          pixel_errors++;
          $display("[ERROR] %0t pixel.index expected %h got %h",
                   $time, last_index + 8'd1, pixel.index);
        end
      end
      assert (pixel.data == video_expect[pixel.index]) else begin
        pixel_errors++;
        $display("[ERROR] %0t pixel.data expected %h got %h (index %h)",
                 $time, video_expect[pixel.index], pixel.data, pixel.index);
      end
      last_index = pixel.index;
    end
  endtask

  task automatic finish_run();
    $display("error counts: %0d write, %0d pixel, %0d other, %0d of %0d writes seen",
             write_errors, pixel_errors, other_errors, writes_seen, write_count);
    if (write_errors + pixel_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // outputs settle well before the falling edge, so they are sampled there
  always @(negedge clk) begin
    if (write_event.valid) begin
      check_write();
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      other_errors++;
      $display("run timed out after %0d cycles with %0d of %0d writes seen",
               cycle_count, writes_seen, write_count);
      finish_run();
    end
  end

  initial begin
    load_valid   = 1'b0;
    load_address = '0;
    load_data    = '0;
    writes_seen  = 0;
    write_errors = 0;
    pixel_errors = 0;
    other_errors = 0;
    cycle_count  = 0;
    read_patterns();
    // room for the slowest instruction mix plus one full scanout sweep
    cycle_limit = 40 * prog_len + 4 * VRAM_WORDS;
    load_program();
    wait (writes_seen == write_count);
    // the program now sits in its final self-loop
    repeat (SETTLE_CYCLES) @(negedge clk);
    check_sweep();
    finish_run();
  end

endmodule

//--- test/hack_patterns.txt
// hex words in order: program length, program words, write count, (address data) pairs,
// scanout count, (index data) pairs
0035
// data memory, add, subtract through memory, AND, OR, negate and constants
1234 EC10 0010 E308 0F0F E090 0011 E308
0010 F4D0 0012 E308 00FF E008 E548 E3C8
EE88 EFC8
// JLT not taken, JGT taken over a stray store, then a loop writing 3 2 1
0016 E304 0018 E301 0014 EA88
0003 EC10 0020 E308 001A E391
// video writes, then video readback copied to data memory, then the self-loop
4005 EE88 2222 EC50 4080 E308 40FE E7C8
4080 FC10 002F EDE0 E308 40FE FC10 0031
E308 4005 FC10 0032 E308 0033 EA87
// expected CPU writes as address data
0011
0010 1234  0011 2143  0012 0F0F
00FF 000F  00FF 0FFF  00FF F0F1  00FF FFFF  00FF 0001
0020 0003  0020 0002  0020 0001
4005 FFFF  4080 DDDD  40FE DDDE
0030 DDDD  0031 DDDE  0032 FFFF
// expected scanout words as index data
0003
0005 FFFF  0080 DDDD  00FE DDDE

//--- list.f
logic/hack_pkg.sv
logic/hack_alu.sv
logic/hack_cpu.sv
logic/program_memory.sv
logic/memory_map.sv
logic/vram_arbiter.sv
logic/video_scanout.sv
logic/hack_system.sv
test/hack_system_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module hack_system_tb -o hack_sim -f list.f
./obj_dir/hack_sim | tee sim.log
if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without errors"
